//--- filelist.f
source/ioBridgePkg.sv
source/ioBusSlave.sv
source/postFifo.sv
source/ioBusMaster.sv
source/ioBridge.sv
test/ioDeviceModel.sv
test/ioBridge_checker.sv
test/ioBridgeTb.sv

//--- test/ioBridgeTb.sv
`timescale 1ns/1ns

module ioBridgeTb;
	import ioBridgePkg::*;

	localparam int numTests = 5;
	localparam int watchdogCycles = 16 + numTests * ackTimeout * 4;

	logic CLK, reset;
	ioAddrT cpuAddr, ioAddr;
	ioDataT cpuDataOut, cpuDataIn, ioWrData, ioRdData;
	logic nAs, nWe, nLds, nUds, dataOe, cpuReady, nBerr;
	byteStrobeT ioStrobe;
	logic ioRw, ioSel, ioAck;
	int seedInit;

	ioBridge uut (.*);
	ioDeviceModel dev (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Timeout: the tests did not finish in time");
		$display("Some tests failed");
		$fatal(1);
	end

	// Protocol checker on the I/O bus
	always @(posedge CLK) begin
		if (uut.master.chk.failCount != 0) begin
			$display("A protocol assertion on the I/O bus failed");
			$display("Some tests failed");
			$fatal(1);
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	function automatic ioDataT mergeBytes(input ioDataT old, input ioDataT nw,
		input byteStrobeT s);
		mergeBytes = old;
		if (s[1])
			mergeBytes[15:8] = nw[15:8];
		if (s[0])
			mergeBytes[7:0] = nw[7:0];
	endfunction

	// One processor cycle held until cpuReady or nBerr
	task automatic cpuCycle(input ioAddrT addr, input ioDataT data, input logic write,
		input byteStrobeT strb, output ioDataT rd, output logic ready, output logic berr,
		output logic oe, output int cycles);
		@(posedge CLK);
		#2;
		cpuAddr = addr;
		cpuDataOut = data;
		nWe = !write;
		{nUds, nLds} = ~strb;
		nAs = 1'b0;
		cycles = 0;
		do begin
			@(posedge CLK);
			#2;
			cycles++;
		end while (!cpuReady && nBerr);
		rd = cpuDataIn;
		ready = cpuReady;
		berr = !nBerr;
		oe = dataOe;
		nAs = 1'b1; // Bus fields stay until the next cycle
		@(posedge CLK);
		#2;
	endtask

	task automatic waitLog(input int n);
		while (dev.logAddr.size() < n)
			@(posedge CLK);
	endtask

	task automatic checkLog(input int idx, input ioAddrT a, input ioDataT d,
		input byteStrobeT s);
		checkValue("logAddr", dev.logAddr[idx], a);
		checkValue("logData", dev.logData[idx], d);
		checkValue("logStrobe", dev.logStrobe[idx], s);
	endtask

	task automatic resetValues();
		checkValue("ioReq", uut.ioReq, 0);
		checkValue("ioAct", uut.ioAct, 0);
		checkValue("latch0", uut.latch0, 0);
		checkValue("latch1", uut.latch1, 0);
		checkValue("ioSel", ioSel, 0);
		checkValue("ioStrobe", ioStrobe, 0);
		checkValue("cpuReady", cpuReady, 0);
		checkValue("dataOe", dataOe, 0);
		checkValue("nBerr", nBerr, 1);
	endtask

	function automatic byteStrobeT randStrobe();
		randStrobe = 2'($urandom_range(1, 3)); // Never both bytes off
	endfunction

	task automatic singlePost();
		ioAddrT a;
		ioDataT d, rd;
		byteStrobeT s;
		logic ready, berr, oe;
		int cyc, base;
		a = postWindowBase | ioAddrT'($urandom & 32'hFFFF);
		d = ioDataT'($urandom);
		s = randStrobe();
		base = dev.logAddr.size();
		cpuCycle(a, d, 1'b1, s, rd, ready, berr, oe, cyc);
		checkValue("cpuReady", ready, 1);
		if (cyc > 2) begin
			$display("Posted write took %0d cycles to get cpuReady", cyc);
			$display("Some tests failed");
			$fatal(1);
		end
		waitLog(base + 1);
		checkLog(base, a, d, s);
	endtask

	task automatic burstPost(input int n);
		ioAddrT ea[$];
		ioDataT ed[$];
		byteStrobeT es[$];
		ioDataT rd;
		logic ready, berr, oe;
		int cyc, base;
		base = dev.logAddr.size();
		for (int i = 0; i < n; i++) begin
			ea.push_back(postWindowBase | ioAddrT'($urandom & 32'hFFFF));
			ed.push_back(ioDataT'($urandom));
			es.push_back(randStrobe());
			dev.ackDelay = $urandom_range(0, 7);
			cpuCycle(ea[i], ed[i], 1'b1, es[i], rd, ready, berr, oe, cyc);
			checkValue("cpuReady", ready, 1);
		end
		waitLog(base + n);
		checkValue("logCount", dev.logAddr.size(), base + n); // Each write once
		for (int i = 0; i < n; i++)
			checkLog(base + i, ea[i], ed[i], es[i]);
	endtask

	task automatic readAndWrite();
		ioAddrT a;
		ioDataT d, rd, exp;
		byteStrobeT s;
		logic ready, berr, oe;
		int cyc;
		a = ioWindowBase | ioAddrT'($urandom & 32'hFFFF); // Outside posting window
		exp = dev.mem[a[7:0]];
		dev.ackDelay = $urandom_range(0, 7);
		cpuCycle(a, 16'h0000, 1'b0, 2'b11, rd, ready, berr, oe, cyc);
		checkValue("cpuReady", ready, 1);
		checkValue("dataOe", oe, 1);
		checkValue("cpuDataIn", rd, exp);
		a = ioWindowBase | ioAddrT'($urandom & 32'hFFFF);
		d = ioDataT'($urandom);
		s = randStrobe();
		exp = mergeBytes(dev.mem[a[7:0]], d, s);
		cpuCycle(a, d, 1'b1, s, rd, ready, berr, oe, cyc);
		checkValue("cpuReady", ready, 1);
		checkValue("mem", dev.mem[a[7:0]], exp); // Updated before cpuReady
	endtask

	task automatic noAckRead();
		ioAddrT a;
		ioDataT rd, exp;
		logic ready, berr, oe;
		int cyc;
		a = ioWindowBase | ioAddrT'($urandom & 32'hFFFF);
		dev.noAck = 1'b1;
		cpuCycle(a, 16'h0000, 1'b0, 2'b11, rd, ready, berr, oe, cyc);
		checkValue("nBerr", !berr, 0);
		checkValue("cpuReady", ready, 0);
		dev.noAck = 1'b0;
		a = ioWindowBase | ioAddrT'($urandom & 32'hFFFF);
		exp = dev.mem[a[7:0]];
		cpuCycle(a, 16'h0000, 1'b0, 2'b11, rd, ready, berr, oe, cyc);
		checkValue("cpuReady", ready, 1);
		checkValue("cpuDataIn", rd, exp);
	endtask

	initial begin
		seedInit = $urandom(32'h81bef561);
		reset = 1'b1;
		nAs = 1'b1;
		nWe = 1'b1;
		nLds = 1'b1;
		nUds = 1'b1;
		cpuAddr = '0;
		cpuDataOut = '0;
		repeat (16) @(posedge CLK);
		#2;
		reset = 1'b0;
		repeat (3) @(posedge CLK);
		#2;
		resetValues();
		singlePost();
		burstPost(6);
		readAndWrite();
		noAckRead();
		if (uut.master.chk.failCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- test/ioBridge_checker.sv
`timescale 1ns/1ns

module ioBridgeChecker (
	input logic CLK,
	input logic reset,
	input logic ioReq,
	input logic ioAct,
	input logic ioSel,
	input ioBridgePkg::byteStrobeT ioStrobe,
	input logic ioDone
);
	int failCount = 0; // Assertion failures so far

	// Data phase only inside an address phase
	strobeInSel: assert property (@(posedge CLK) disable iff (reset)
		(ioStrobe != 2'b00) |-> ioSel)
		else begin
			$error("ioStrobe active without ioSel");
			failCount++;
		end

	// Request drops only once the master has taken it
	reqAfterAct: assert property (@(posedge CLK) disable iff (reset)
		$fell(ioReq) |-> $past(ioAct))
		else begin
			$error("ioReq fell before ioAct was seen");
			failCount++;
		end

	doneSingle: assert property (@(posedge CLK) disable iff (reset)
		ioDone |=> !ioDone)
		else begin
			$error("ioDone longer than one cycle");
			failCount++;
		end

endmodule

bind ioBusMaster ioBridgeChecker chk (
	.CLK(CLK), .reset(reset),
	.ioReq(ioReq), .ioAct(ioAct), .ioSel(ioSel),
	.ioStrobe(ioStrobe), .ioDone(ioDone)
);

//--- test/ioDeviceModel.sv
`timescale 1ns/1ns

module ioDeviceModel (
	input logic CLK,
	input logic reset,
	input ioBridgePkg::ioAddrT ioAddr,
	input ioBridgePkg::ioDataT ioWrData,
	input ioBridgePkg::byteStrobeT ioStrobe,
	input logic ioRw,
	input logic ioSel,
	output logic ioAck,
	output ioBridgePkg::ioDataT ioRdData
);
	import ioBridgePkg::*;

	ioDataT mem [0:255];     // Register file on the low address bits
	int ackDelay = 0;        // Cycles of strobe before acknowledge
	logic noAck = 1'b0;      // Never acknowledge when set
	int waitCnt;
	ioAddrT logAddr[$];      // Write log with one entry per acknowledged write
	ioDataT logData[$];
	byteStrobeT logStrobe[$];

	assign ioRdData = mem[ioAddr[7:0]];

	always @(posedge CLK) begin
		if (reset) begin
			ioAck <= 1'b0;
			waitCnt <= 0;
			for (int i = 0; i < 256; i++)
				mem[i] <= {i[7:0] ^ 8'h5A, i[7:0] ^ 8'hC3}; // Pattern from the full index
		end else begin
			ioAck <= 1'b0; // One cycle acknowledge
			if (!ioSel || ioStrobe == 2'b00)
				waitCnt <= 0;
			else if (!ioAck && !noAck) begin
				if (waitCnt >= ackDelay) begin
					ioAck <= 1'b1;
					waitCnt <= 0;
					if (!ioRw) begin
						if (ioStrobe[1])
							mem[ioAddr[7:0]][15:8] <= ioWrData[15:8];
						if (ioStrobe[0])
							mem[ioAddr[7:0]][7:0] <= ioWrData[7:0];
						logAddr.push_back(ioAddr);
						logData.push_back(ioWrData);
						logStrobe.push_back(ioStrobe);
					end
				end else
					waitCnt <= waitCnt + 1;
			end
		end
	end

endmodule

//--- source/ioBridge.sv
`timescale 1ns/1ns

module ioBridge (
	input logic CLK,
	input logic reset,
	// Processor side
	input ioBridgePkg::ioAddrT cpuAddr,
	input ioBridgePkg::ioDataT cpuDataOut,
	input logic nAs,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	output ioBridgePkg::ioDataT cpuDataIn,
	output logic dataOe,
	output logic cpuReady,
	output logic nBerr,
	// I/O bus side
	output ioBridgePkg::ioAddrT ioAddr,
	output ioBridgePkg::ioDataT ioWrData,
	output ioBridgePkg::byteStrobeT ioStrobe,
	output logic ioRw,
	output logic ioSel,
	input logic ioAck,
	input ioBridgePkg::ioDataT ioRdData
);
	import ioBridgePkg::*;

	logic ioReq, ioAct, ioDone, ioErrN;
	logic latch0, latch1;
	logic rw0;
	byteStrobeT strobe0;
	ioAddrT addr0;
	ioDataT data0;
	ioDataT rdData;

	ioBusSlave slave (
		.CLK(CLK), .reset(reset),
		.cpuAddr(cpuAddr), .nAs(nAs), .nWe(nWe), .nLds(nLds), .nUds(nUds),
		.ioAct(ioAct), .ioDone(ioDone), .ioErrN(ioErrN),
		.ioReq(ioReq),
		.latch0(latch0), .latch1(latch1),
		.strobe0(strobe0), .strobe1(), // Level 1 strobes stay in the slave
		.rw0(rw0), .rw1(),
		.cpuReady(cpuReady), .nBerr(nBerr), .dataOe(dataOe)
	);

	postFifo fifo (
		.CLK(CLK), .reset(reset),
		.latch0(latch0), .latch1(latch1),
		.cpuAddr(cpuAddr), .cpuDataOut(cpuDataOut),
		.addr0(addr0), .data0(data0)
	);

	ioBusMaster master (
		.CLK(CLK), .reset(reset),
		.ioReq(ioReq),
		.addr0(addr0), .data0(data0), .strobe0(strobe0), .rw0(rw0),
		.ioAct(ioAct), .ioDone(ioDone), .ioErrN(ioErrN),
		.rdData(rdData),
		.ioAddr(ioAddr), .ioWrData(ioWrData), .ioStrobe(ioStrobe),
		.ioRw(ioRw), .ioSel(ioSel),
		.ioAck(ioAck), .ioRdData(ioRdData)
	);

	// Last read word back to the processor
	assign cpuDataIn = rdData;

endmodule

//--- source/ioBusMaster.sv
`timescale 1ns/1ns

module ioBusMaster (
	input logic CLK,
	input logic reset,
	input logic ioReq,
	input ioBridgePkg::ioAddrT addr0,
	input ioBridgePkg::ioDataT data0,
	input ioBridgePkg::byteStrobeT strobe0,
	input logic rw0,
	output logic ioAct,
	output logic ioDone,
	output logic ioErrN,
	output ioBridgePkg::ioDataT rdData,
	output ioBridgePkg::ioAddrT ioAddr,
	output ioBridgePkg::ioDataT ioWrData,
	output ioBridgePkg::byteStrobeT ioStrobe,
	output logic ioRw,
	output logic ioSel,
	input logic ioAck,
	input ioBridgePkg::ioDataT ioRdData
);
	import ioBridgePkg::*;

	typedef enum logic [1:0] {
		cycIdle,   // Waiting for ioReq
		cycSetup,  // Select on, strobe held off
		cycWait    // Strobe on, waiting for ioAck
	} cycStateT;

	cycStateT cycState;
	logic [setupCntW-1:0] setupCnt;  // Setup delay
	logic [ackCntW-1:0] ackCnt;      // Acknowledge timeout
	logic setupLast;
	logic ackLast;

	assign setupLast = setupCnt == setupCntW'(setupCycles - 1);
	assign ackLast = ackCnt == ackCntW'(ackTimeout - 1);

	// Address and direction come straight from level 0
	assign ioAddr = addr0;
	assign ioRw = rw0;
	assign ioWrData = rw0 ? '0 : data0; // Write data only on writes

	// Cycle engine
	always_ff @(posedge CLK) begin
		if (reset) begin
			cycState <= cycIdle;
			ioAct <= 1'b0;
			ioSel <= 1'b0;
			ioStrobe <= '0;
			ioDone <= 1'b0;
			ioErrN <= 1'b1;
			setupCnt <= '0;
			ackCnt <= '0;
		end else begin
			ioDone <= 1'b0;  // Single cycle pulse
			ioErrN <= 1'b1;
			case (cycState)
				cycIdle: begin
					if (ioReq) begin
						cycState <= cycSetup;
						ioAct <= 1'b1;
						ioSel <= 1'b1;    // Address phase begins
						setupCnt <= '0;
					end
				end
				cycSetup: begin
					if (setupLast) begin
						cycState <= cycWait;
						ioStrobe <= strobe0;  // Data phase
						ackCnt <= '0;
					end else begin
						setupCnt <= setupCnt + 1'b1;
					end
				end
				cycWait: begin
					if (ioAck || ackLast) begin
						cycState <= cycIdle;
						ioAct <= 1'b0;
						ioSel <= 1'b0;
						ioStrobe <= '0;
						ioDone <= 1'b1;
						ioErrN <= ioAck;  // Low only on timeout
					end else begin
						ackCnt <= ackCnt + 1'b1;
					end
				end
				default: cycState <= cycIdle;
			endcase
		end
	end

	// Read data held until the next read completes
	always_ff @(posedge CLK) begin
		if (cycState == cycWait && ioAck && rw0)
			rdData <= ioRdData;
	end

endmodule

//--- source/postFifo.sv
`timescale 1ns/1ns

module postFifo (
	input logic CLK,
	input logic reset,
	input logic latch0,
	input logic latch1,
	input ioBridgePkg::ioAddrT cpuAddr,
	input ioBridgePkg::ioDataT cpuDataOut,
	output ioBridgePkg::ioAddrT addr0,
	output ioBridgePkg::ioDataT data0
);
	import ioBridgePkg::*;

	ioAddrT addr1;     // Secondary level
	ioDataT data1;
	ioAddrT addr0Src;  // Next primary contents
	ioDataT data0Src;

	// Secondary level follows the bus until latch1 is set
	// The edge where latch1 rises keeps the posted write
	always_ff @(posedge CLK) begin
		if (!latch1) begin
			addr1 <= cpuAddr;
			data1 <= cpuDataOut;
		end
	end

	// Secondary level wins the primary source while it holds a write
	always_comb begin
		if (latch1) begin
			addr0Src = addr1;
			data0Src = data1;
		end else begin
			addr0Src = cpuAddr;
			data0Src = cpuDataOut;
		end
	end

	// Primary level tracks its source until latch0 freezes it
	always_ff @(posedge CLK) begin
		if (reset) begin
			addr0 <= '0;
			data0 <= '0;
		end else if (!latch0) begin
			addr0 <= addr0Src;
			data0 <= data0Src;
		end
	end

endmodule

//--- source/ioBusSlave.sv
`timescale 1ns/1ns

module ioBusSlave (
	input logic CLK,
	input logic reset,
	input ioBridgePkg::ioAddrT cpuAddr,
	input logic nAs,
	input logic nWe,
	input logic nLds,
	input logic nUds,
	input logic ioAct,
	input logic ioDone,
	input logic ioErrN,
	output logic ioReq,
	output logic latch0,
	output logic latch1,
	output ioBridgePkg::byteStrobeT strobe0,
	output ioBridgePkg::byteStrobeT strobe1,
	output logic rw0,
	output logic rw1,
	output logic cpuReady,
	output logic nBerr,
	output logic dataOe
);
	import ioBridgePkg::*;

	xferStateT state;
	logic busActive;        // nAs low, one cycle late
	logic ioHit;            // Address in I/O window
	logic postHit;          // Write in posting window
	logic sent;             // Current processor cycle already handed off
	logic load1;            // Level 1 captures on next edge
	logic clear1;           // Level 1 has been copied down
	logic npReady;          // Non-posted completion
	logic startXfer;
	byteStrobeT cpuStrobe;

	// Window decode
	assign ioHit = (cpuAddr & ioWindowMask) == ioWindowBase;
	assign postHit = ioHit && !nWe && ((cpuAddr & postWindowMask) == postWindowBase);
	assign cpuStrobe = {!nUds, !nLds}; // Active high byte enables

	// Read data drive while a read in the window is open
	assign dataOe = !nAs && busActive && ioHit && nWe;

	// Idle start takes level 1 first, else a fresh processor hit
	assign startXfer = latch1 || (busActive && ioHit && !sent);

	always_ff @(posedge CLK) begin
		if (reset)
			busActive <= 1'b0;
		else
			busActive <= !nAs;
	end

	// Secondary level control
	always_ff @(posedge CLK) begin
		if (reset) begin
			load1 <= 1'b0;
			clear1 <= 1'b0;
			latch1 <= 1'b0;
		end else begin
			// Post behind a running transfer when level 1 is free
			load1 <= busActive && postHit && !latch1 && !sent && state != xferIdle;
			clear1 <= state == xferStart; // Level 1 consumed by this start
			if (load1)
				latch1 <= 1'b1;
			else if (clear1)
				latch1 <= 1'b0;
		end
	end

	// Level 1 strobes and direction caught with the address
	always_ff @(posedge CLK) begin
		if (load1) begin
			strobe1 <= cpuStrobe;
			rw1 <= nWe;
		end
	end

	// Transfer FSM
	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= xferIdle;
			ioReq <= 1'b0;
			latch0 <= 1'b0;
		end else begin
			case (state)
				xferIdle: begin
					latch0 <= 1'b0; // Level 0 follows its source
					if (startXfer) begin
						state <= xferStart;
						ioReq <= 1'b1;
					end
				end
				xferStart: begin
					state <= xferWaitAct;
					latch0 <= 1'b1; // Freeze level 0
				end
				xferWaitAct: begin
					if (ioAct) begin
						state <= xferWaitDone;
						ioReq <= 1'b0; // Master has it
					end
				end
				xferWaitDone: begin
					if (!ioAct) begin
						state <= xferIdle; // Cycle over and level 0 free
					end
				end
				default: state <= xferIdle;
			endcase
		end
	end

	// Level 0 strobes and direction reloaded in idle and start
	always_ff @(posedge CLK) begin
		if (state == xferIdle || state == xferStart) begin
			if (latch1) begin
				strobe0 <= strobe1;
				rw0 <= rw1;
			end else begin
				strobe0 <= cpuStrobe;
				rw0 <= nWe; // High for read
			end
		end
	end

	// Handoff flag for the current processor cycle
	always_ff @(posedge CLK) begin
		if (reset)
			sent <= 1'b0;
		else if (nAs)
			sent <= 1'b0; // Cleared as the processor ends its cycle
		else if (busActive && ioHit && !latch1 && (postHit || state == xferIdle))
			sent <= 1'b1;
	end

	// Non-posted completion and bus error
	always_ff @(posedge CLK) begin
		if (reset) begin
			npReady <= 1'b0;
			nBerr <= 1'b1;
		end else if (nAs) begin
			npReady <= 1'b0;
			nBerr <= 1'b1;
		end else if (sent && !postHit && ioDone) begin
			npReady <= ioErrN;   // Normal end
			nBerr <= ioErrN;     // Timeout ends with bus error instead
		end
	end

	// Posted writes end as soon as they are handed off
	assign cpuReady = (sent && postHit) || npReady;

endmodule

//--- source/ioBridgePkg.sv
package ioBridgePkg;

	// Bus widths
	typedef logic [22:0] ioAddrT;     // Word address from processor A23..A1
	typedef logic [15:0] ioDataT;     // One data word
	typedef logic [1:0] byteStrobeT;  // [1] upper byte, [0] lower byte

	// I/O window matched on the top address bits
	localparam ioAddrT ioWindowBase = 23'h7C0000;
	localparam ioAddrT ioWindowMask = 23'h7E0000;

	// Posting sub-window inside the I/O window for writes only
	localparam ioAddrT postWindowBase = 23'h7D0000;
	localparam ioAddrT postWindowMask = 23'h7F0000;

	// I/O bus timing in CLK cycles
	localparam int setupCycles = 2;  // ioSel to ioStrobe
	localparam int ackTimeout = 32;  // Acknowledge wait before bus error

	// Counter widths sized from the timing above
	localparam int setupCntW = $clog2(setupCycles + 1);
	localparam int ackCntW = $clog2(ackTimeout + 1);

	// Slave transfer state
	typedef enum logic [1:0] {
		xferIdle,     // Nothing in flight
		xferStart,    // Level 0 loading with request raised
		xferWaitAct,  // Waiting for master to pick up
		xferWaitDone  // Master owns the cycle
	} xferStateT;

endpackage
